// ==== bp_pkg.sv ====
// shared branch kinds, record and update formats, and sizing for the branch update stage
package bp_pkg;

    localparam int BH_WIDTH    = 14;
    localparam int PC_WIDTH    = 30;  // word address
    localparam int REC_DEPTH   = 8;   // record queue entries, also initial input credits
    localparam int PTR_W       = $clog2(REC_DEPTH);
    localparam int UPD_CREDITS = 4;   // update slots at the predictor
    localparam int CNT_W       = 4;

    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        CALL          = 3'd6,
        JUMP          = 3'd7
    } br_kind_t;

    // one resolved instruction as reported by an execution lane
    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic                taken_pdc;
        br_kind_t            kind_pdc;
        logic [PC_WIDTH-1:0] npc_pdc;
        logic [BH_WIDTH-1:0] bh_pdc;
        logic                taken_ex;
        br_kind_t            kind_ex;
        logic [PC_WIDTH-1:0] npc_ex;
        logic                pack_size;  // packet held two instructions
        logic                flush_pre;  // second one squashed, never reported
    } branch_rec_t;

    // one folded packet toward the predictor tables
    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic                taken_pdc;
        br_kind_t            kind_pdc;
        logic [PC_WIDTH-1:0] npc_pdc;
        logic [BH_WIDTH-1:0] bh_pdc;
        logic                taken_ex;
        br_kind_t            kind_ex;
        logic [PC_WIDTH-1:0] npc_ex;
        logic [PC_WIDTH-1:0] ret_pc;
    } bp_update_t;

endpackage

// ==== bp_update_checker.sv ====
// handshake assertions for the branch update stage, bound into the top level
module bp_update_checker import bp_pkg::*; (
    input logic             clk,
    input logic             rstn,
    input logic             upd_valid,
    input logic [1:0]       ex_credit,
    input logic [CNT_W-1:0] credit_cnt,
    input logic             upd_credit
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [CNT_W-1:0] in_flight;  // updates at the predictor not yet credited back

    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + CNT_W'(upd_valid) - CNT_W'(upd_credit);
        end
    end

    // each update needs a free slot at the predictor
    a_send_has_credit: assert property (@(posedge clk) disable iff (!rstn)
        upd_valid |-> (in_flight < CNT_W'(UPD_CREDITS)))
        else $error("update sent with no credit left");

    a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
        credit_cnt <= CNT_W'(UPD_CREDITS))
        else $error("credit counter above slot count");

    a_ex_credit_range: assert property (@(posedge clk) disable iff (!rstn)
        ex_credit != 2'd3)
        else $error("ex_credit reported three records");

    // first cycle out of reset
    a_reset_clear: assert property (@(posedge clk)
        (rstn && $past(!rstn)) |-> (upd_valid == 1'b0 && ex_credit == 2'd0))
        else $error("outputs not cleared after reset");

endmodule

bind bp_update_unit bp_update_checker u_chk (
    .clk        (clk),
    .rstn       (rstn),
    .upd_valid  (upd_valid),
    .ex_credit  (ex_credit),
    .credit_cnt (u_send.credit_cnt),
    .upd_credit (upd_credit)
);

// ==== bp_update_unit.sv ====
// branch update stage top, lane records in, credited predictor updates out
module bp_update_unit import bp_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic [1:0]          in_valid,  // bit 0 is the older lane
    // lane 0
    input  logic [PC_WIDTH-1:0] ex0_pc,
    input  logic                ex0_taken_pdc,
    input  br_kind_t            ex0_kind_pdc,
    input  logic [PC_WIDTH-1:0] ex0_npc_pdc,
    input  logic [BH_WIDTH-1:0] ex0_bh_pdc,
    input  logic                ex0_taken_ex,
    input  br_kind_t            ex0_kind_ex,
    input  logic [PC_WIDTH-1:0] ex0_npc_ex,
    input  logic                ex0_pack_size,
    input  logic                ex0_flush_pre,
    // lane 1
    input  logic [PC_WIDTH-1:0] ex1_pc,
    input  logic                ex1_taken_pdc,
    input  br_kind_t            ex1_kind_pdc,
    input  logic [PC_WIDTH-1:0] ex1_npc_pdc,
    input  logic [BH_WIDTH-1:0] ex1_bh_pdc,
    input  logic                ex1_taken_ex,
    input  br_kind_t            ex1_kind_ex,
    input  logic [PC_WIDTH-1:0] ex1_npc_ex,
    input  logic                ex1_pack_size,
    input  logic                ex1_flush_pre,
    output logic [1:0]          ex_credit,  // records freed last edge
    output logic                upd_valid,
    output bp_update_t          upd_data,
    input  logic                upd_credit
);

    branch_rec_t rec0;
    branch_rec_t rec1;
    logic        merge_valid;
    bp_update_t  merge_upd;
    logic        merge_ready;

    rec_if u_rec ();

    assign rec0 = '{ex0_pc, ex0_taken_pdc, ex0_kind_pdc, ex0_npc_pdc, ex0_bh_pdc,
                    ex0_taken_ex, ex0_kind_ex, ex0_npc_ex, ex0_pack_size, ex0_flush_pre};
    assign rec1 = '{ex1_pc, ex1_taken_pdc, ex1_kind_pdc, ex1_npc_pdc, ex1_bh_pdc,
                    ex1_taken_ex, ex1_kind_ex, ex1_npc_ex, ex1_pack_size, ex1_flush_pre};

    branch_rec_fifo u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (in_valid),
        .wr_rec0 (rec0),
        .wr_rec1 (rec1),
        .rd      (u_rec.queue)
    );

    pack_merge u_merge (
        .rd        (u_rec.merger),
        .upd_valid (merge_valid),
        .upd       (merge_upd),
        .upd_ready (merge_ready)
    );

    update_sender u_send (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (merge_valid),
        .in_upd     (merge_upd),
        .in_ready   (merge_ready),
        .upd_valid  (upd_valid),
        .upd_data   (upd_data),
        .upd_credit (upd_credit)
    );

    // popped slots go back to the lanes as credits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_credit <= 2'd0;
        end else begin
            ex_credit <= u_rec.pop_cnt;
        end
    end

endmodule

// ==== branch_rec_fifo.sv ====
// in-order record queue, two writes and up to two pops per cycle, heads read combinationally
module branch_rec_fifo import bp_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic [1:0]  wr_en,
    input  branch_rec_t wr_rec0,
    input  branch_rec_t wr_rec1,
    rec_if.queue        rd
);

    branch_rec_t mem [REC_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [1:0]       wr_num;
    branch_rec_t      wr_first;

    assign wr_num = {1'b0, wr_en[0]} + {1'b0, wr_en[1]};

    // lane 1 alone lands in the first free slot
    assign wr_first = wr_en[0] ? wr_rec0 : wr_rec1;

    always_ff @(posedge clk) begin
        if (wr_num != 2'd0) begin
            mem[wr_ptr] <= wr_first;
        end
        if (wr_en == 2'b11) begin
            mem[wr_ptr + PTR_W'(1)] <= wr_rec1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(wr_num);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(rd.pop_cnt);
        end
    end

    // producer holds credits, so count never passes REC_DEPTH
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(wr_num) - CNT_W'(rd.pop_cnt);
        end
    end

    assign rd.head0 = mem[rd_ptr];
    assign rd.head1 = mem[rd_ptr + PTR_W'(1)];
    assign rd.count = count;

endmodule

// ==== flist.f ====
bp_pkg.sv
rec_if.sv
branch_rec_fifo.sv
pack_merge.sv
update_sender.sv
bp_update_unit.sv
bp_update_checker.sv
tb_bp_update.sv

// ==== pack_merge.sv ====
// folds the head packet of the record queue into a single predictor update
module pack_merge import bp_pkg::*; (
    rec_if.merger      rd,
    output logic       upd_valid,
    output bp_update_t upd,
    input  logic       upd_ready
);

    branch_rec_t h0;
    branch_rec_t h1;
    logic        single;
    logic        fire;

    assign h0 = rd.head0;
    assign h1 = rd.head1;

    // second slot of the packet is absent or squashed
    assign single = ~h0.pack_size | h0.flush_pre;

    assign upd_valid = (rd.count >= CNT_W'(2)) || (rd.count == CNT_W'(1) && single);
    assign fire      = upd_valid & upd_ready;
    assign rd.pop_cnt = !fire ? 2'd0 : (single ? 2'd1 : 2'd2);

    always_comb begin
        upd.pc        = h0.pc;
        upd.taken_pdc = h0.taken_pdc;
        upd.kind_pdc  = h0.kind_pdc;
        upd.npc_pdc   = h0.npc_pdc;
        upd.bh_pdc    = h0.bh_pdc;
        upd.ret_pc    = h0.pc + PC_WIDTH'(1);

        if (single) begin
            upd.taken_ex = h0.taken_ex;
            upd.kind_ex  = h0.kind_ex;
            upd.npc_ex   = h0.npc_ex;
        end else begin
            upd.taken_ex = h0.taken_ex | h1.taken_ex;

            // kind priority across the pair
            if (h0.kind_ex == DIRECT_JUMP || h1.kind_ex == DIRECT_JUMP) begin
                upd.kind_ex = DIRECT_JUMP;
            end else if (h0.kind_ex == CALL || h1.kind_ex == CALL) begin
                upd.kind_ex = CALL;
            end else if (h0.kind_ex == RET || h1.kind_ex == RET) begin
                upd.kind_ex = RET;
            end else if (h0.kind_ex == INDIRECT_JUMP || h1.kind_ex == INDIRECT_JUMP) begin
                upd.kind_ex = INDIRECT_JUMP;
            end else begin
                upd.kind_ex = NOT_JUMP;
            end

            upd.npc_ex = h0.taken_ex ? h0.npc_ex : h1.npc_ex;

            if (h1.kind_ex == CALL && h0.kind_ex != CALL) begin
                upd.ret_pc = h1.pc + PC_WIDTH'(1);  // call sits in the second slot
            end
        end
    end

endmodule

// ==== rec_if.sv ====
// record queue head view shared between the queue and the packet merger
interface rec_if import bp_pkg::*; ();

    branch_rec_t      head0;    // oldest entry
    branch_rec_t      head1;    // next oldest
    logic [CNT_W-1:0] count;    // occupancy
    logic [1:0]       pop_cnt;  // 0, 1 or 2

    modport queue (
        output head0,
        output head1,
        output count,
        input  pop_cnt
    );

    modport merger (
        input  head0,
        input  head1,
        input  count,
        output pop_cnt
    );

endinterface

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_bp_update -o sim_bp_update
./obj_dir/sim_bp_update | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
grep -q ">>> PASS" sim.log

// ==== tb_bp_update.sv ====
// testbench for the branch update stage, random lanes and credit return checked against a model
module tb_bp_update import bp_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PKTS = 300;
    localparam int MAX_WAIT = 20000;

    logic        clk;
    logic        rstn;
    logic [1:0]  in_valid;
    branch_rec_t lane0;
    branch_rec_t lane1;
    logic [1:0]  ex_credit;
    logic        upd_valid;
    bp_update_t  upd_data;
    logic        upd_credit;

    logic [31:0] rng_state = 32'd17;
    branch_rec_t send_q [$];  // records not yet offered to a lane
    bp_update_t  exp_q [$];   // expected updates, packet order
    br_kind_t    kinds [6] = '{NOT_JUMP, DIRECT_JUMP, RET, INDIRECT_JUMP, CALL, JUMP};
    int          credits = REC_DEPTH;
    int          pkts_made = 0;
    int          rec_sent = 0;
    int          rec_freed = 0;
    int          received = 0;
    int          returned = 0;
    int          ret_delay = 0;

    bp_update_unit u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .in_valid      (in_valid),
        .ex0_pc        (lane0.pc),
        .ex0_taken_pdc (lane0.taken_pdc),
        .ex0_kind_pdc  (lane0.kind_pdc),
        .ex0_npc_pdc   (lane0.npc_pdc),
        .ex0_bh_pdc    (lane0.bh_pdc),
        .ex0_taken_ex  (lane0.taken_ex),
        .ex0_kind_ex   (lane0.kind_ex),
        .ex0_npc_ex    (lane0.npc_ex),
        .ex0_pack_size (lane0.pack_size),
        .ex0_flush_pre (lane0.flush_pre),
        .ex1_pc        (lane1.pc),
        .ex1_taken_pdc (lane1.taken_pdc),
        .ex1_kind_pdc  (lane1.kind_pdc),
        .ex1_npc_pdc   (lane1.npc_pdc),
        .ex1_bh_pdc    (lane1.bh_pdc),
        .ex1_taken_ex  (lane1.taken_ex),
        .ex1_kind_ex   (lane1.kind_ex),
        .ex1_npc_ex    (lane1.npc_ex),
        .ex1_pack_size (lane1.pack_size),
        .ex1_flush_pre (lane1.flush_pre),
        .ex_credit     (ex_credit),
        .upd_valid     (upd_valid),
        .upd_data      (upd_data),
        .upd_credit    (upd_credit)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rnd();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic bit chance(input int unsigned m);
        return (rnd() % m) == 0;  // one in m
    endfunction

    function automatic br_kind_t rand_kind();
        logic [2:0] idx;
        idx = 3'(rnd() % 6);
        return kinds[idx];
    endfunction

    function automatic branch_rec_t rand_rec();
        logic [127:0] raw;
        branch_rec_t  r;
        raw = {rnd(), rnd(), rnd(), rnd()};
        r = raw[$bits(branch_rec_t)-1:0];
        r.kind_pdc = rand_kind();
        r.kind_ex  = rand_kind();
        return r;
    endfunction

    function automatic bit has_kind(input branch_rec_t a, input branch_rec_t b, input br_kind_t k);
        return a.kind_ex == k || b.kind_ex == k;
    endfunction

    // reference fold of one packet
    function automatic bp_update_t build_update(input branch_rec_t a, input branch_rec_t b,
                                                input bit two);
        bp_update_t u;
        u.pc        = a.pc;
        u.taken_pdc = a.taken_pdc;
        u.kind_pdc  = a.kind_pdc;
        u.npc_pdc   = a.npc_pdc;
        u.bh_pdc    = a.bh_pdc;
        u.taken_ex  = a.taken_ex;
        u.kind_ex   = a.kind_ex;
        u.npc_ex    = a.npc_ex;
        u.ret_pc    = a.pc + PC_WIDTH'(1);
        if (two) begin
            u.taken_ex = a.taken_ex | b.taken_ex;
            if (has_kind(a, b, DIRECT_JUMP)) u.kind_ex = DIRECT_JUMP;
            else if (has_kind(a, b, CALL)) u.kind_ex = CALL;
            else if (has_kind(a, b, RET)) u.kind_ex = RET;
            else if (has_kind(a, b, INDIRECT_JUMP)) u.kind_ex = INDIRECT_JUMP;
            else u.kind_ex = NOT_JUMP;
            if (!a.taken_ex) u.npc_ex = b.npc_ex;
            if (b.kind_ex == CALL && a.kind_ex != CALL) u.ret_pc = b.pc + PC_WIDTH'(1);
        end
        return u;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0d ns: %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic new_packet();
        branch_rec_t a;
        branch_rec_t b;
        bit          two;
        a = rand_rec();
        b = rand_rec();
        a.pack_size = chance(2);
        a.flush_pre = a.pack_size & chance(4);
        b.pc        = a.pc + PC_WIDTH'(1);
        b.pack_size = 1'b1;
        b.flush_pre = 1'b0;
        two = a.pack_size & ~a.flush_pre;
        send_q.push_back(a);
        if (two) send_q.push_back(b);  // squashed second slot never reported
        exp_q.push_back(build_update(a, b, two));
        pkts_made++;
    endtask

    task automatic check_outputs();
        bp_update_t e;
        credits   = credits + int'(ex_credit);
        rec_freed = rec_freed + int'(ex_credit);
        check_val("input credits within depth", 64'(credits <= REC_DEPTH), 64'(1));
        if (upd_valid) begin
            if (exp_q.size() == 0) fail_run("an update arrived while none was expected");
            e = exp_q.pop_front();
            check_val("upd_data.pc", 64'(upd_data.pc), 64'(e.pc));
            check_val("upd_data.taken_pdc", 64'(upd_data.taken_pdc), 64'(e.taken_pdc));
            check_val("upd_data.kind_pdc", 64'(upd_data.kind_pdc), 64'(e.kind_pdc));
            check_val("upd_data.npc_pdc", 64'(upd_data.npc_pdc), 64'(e.npc_pdc));
            check_val("upd_data.bh_pdc", 64'(upd_data.bh_pdc), 64'(e.bh_pdc));
            check_val("upd_data.taken_ex", 64'(upd_data.taken_ex), 64'(e.taken_ex));
            check_val("upd_data.kind_ex", 64'(upd_data.kind_ex), 64'(e.kind_ex));
            check_val("upd_data.npc_ex", 64'(upd_data.npc_ex), 64'(e.npc_ex));
            check_val("upd_data.ret_pc", 64'(upd_data.ret_pc), 64'(e.ret_pc));
            received++;
            check_val("outstanding updates", 64'(received - returned <= UPD_CREDITS), 64'(1));
        end
    endtask

    // predictor side, now and then holds its credits back for a long stretch
    task automatic return_credit();
        upd_credit = 1'b0;
        if (received > returned) begin
            if (ret_delay == 0) begin
                upd_credit = 1'b1;
                returned++;
                ret_delay = chance(8) ? 30 : int'(rnd() % 4);
            end else begin
                ret_delay--;
            end
        end
    endtask

    task automatic drive_lanes();
        int n;
        n = int'(rnd() % 3);
        if (n > credits) n = credits;
        while (send_q.size() < n && pkts_made < NUM_PKTS) new_packet();
        if (n > send_q.size()) n = send_q.size();
        in_valid = 2'b00;
        if (n == 2) begin
            lane0    = send_q.pop_front();
            lane1    = send_q.pop_front();
            in_valid = 2'b11;
        end else if (n == 1 && chance(2)) begin
            lane1    = send_q.pop_front();  // lane 1 alone
            in_valid = 2'b10;
        end else if (n == 1) begin
            lane0    = send_q.pop_front();
            in_valid = 2'b01;
        end
        credits  = credits - n;
        rec_sent = rec_sent + n;
    endtask

    task automatic run_cycle();
        @(negedge clk);
        check_outputs();
        return_credit();
        drive_lanes();
    endtask

    initial begin
        int cyc;
        clk        = 1'b0;
        rstn       = 1'b0;
        in_valid   = 2'b00;
        lane0      = '0;
        lane1      = '0;
        upd_credit = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        cyc = 0;
        while (pkts_made < NUM_PKTS || send_q.size() != 0) begin
            run_cycle();
            cyc++;
            if (cyc > MAX_WAIT) fail_run("timeout while sending records to the lanes");
        end

        // ex_credit lands in the same cycle as the last update
        cyc = 0;
        while (exp_q.size() != 0) begin
            run_cycle();
            cyc++;
            if (cyc > MAX_WAIT) fail_run("timeout waiting for the remaining updates");
        end

        check_val("ex_credit total", 64'(rec_freed), 64'(rec_sent));
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== update_sender.sv ====
// output register for predictor updates with a credit counter for the update slots
module update_sender import bp_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       in_valid,
    input  bp_update_t in_upd,
    output logic       in_ready,
    output logic       upd_valid,
    output bp_update_t upd_data,
    input  logic       upd_credit
);

    logic [CNT_W-1:0] credit_cnt;
    logic             send;

    // a credit coming back this cycle is usable right away
    assign in_ready = (credit_cnt != '0) | upd_credit;
    assign send     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credit_cnt <= CNT_W'(UPD_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CNT_W'(upd_credit) - CNT_W'(send);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= send;  // one cycle per update
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            upd_data <= in_upd;
        end
    end

endmodule
